//--- adjacency_map.sv
`timescale 1ns/1ps
`default_nettype none
`include "graph_settings.svh"

module adjacency_map (
    input  wire                     tck,
    input  wire                     rst_n_i,
    input  wire                     edge_valid_i,
    input  wire graph_pkg::edge_s   edge_i,
    input  wire                     query_valid_i,
    input  wire graph_pkg::query_s  query_i,
    output logic                    reply_valid_o,
    output graph_pkg::reply_s       reply_o
);

    graph_pkg::edge_idx_t head_q [`GRAPH_MAX_NODES];
    graph_pkg::edge_idx_t next_q [`GRAPH_MAX_EDGES];
    graph_pkg::node_t     dst_q  [`GRAPH_MAX_EDGES];
    // Slot is the last entry of its list
    logic                 tail_q [`GRAPH_MAX_EDGES];

    logic [`GRAPH_MAX_NODES-1:0]       head_vld_q;
    logic [$clog2(`GRAPH_MAX_EDGES):0] edge_cnt_q;
    graph_pkg::edge_idx_t              slot;

    logic                 walk_q;
    logic                 pending_q;
    logic                 empty_q;
    graph_pkg::edge_idx_t ptr_q;

    assign slot = graph_pkg::edge_idx_t'(edge_cnt_q);

    always_ff @(posedge tck) begin
        if (!rst_n_i) begin
            head_vld_q <= '0;
            edge_cnt_q <= '0;
        end else if (edge_valid_i) begin
            head_vld_q[edge_i.src] <= 1'b1;
            edge_cnt_q             <= edge_cnt_q + 1'b1;
        end
    end

    // Push onto the front of the source list
    always_ff @(posedge tck) begin
        if (edge_valid_i) begin
            head_q[edge_i.src] <= slot;
            next_q[slot]       <= head_q[edge_i.src];
            tail_q[slot]       <= !head_vld_q[edge_i.src];
            dst_q[slot]        <= edge_i.dst;
        end
    end

    always_ff @(posedge tck) begin
        if (!rst_n_i) begin
            walk_q        <= 1'b0;
            pending_q     <= 1'b0;
            reply_valid_o <= 1'b0;
        end else begin
            reply_valid_o <= walk_q;
            if (query_valid_i) begin
                walk_q    <= 1'b1;
                pending_q <= 1'b1;
            end else if (walk_q && (empty_q || tail_q[ptr_q])) begin
                walk_q <= 1'b0;
            end
            if (reply_valid_o && reply_o.last) begin
                pending_q <= 1'b0;
            end
        end
    end

    // Head lookup in the query cycle, then one list entry per cycle
    always_ff @(posedge tck) begin
        if (query_valid_i) begin
            ptr_q   <= head_q[query_i.node];
            empty_q <= !head_vld_q[query_i.node];
        end else if (walk_q) begin
            ptr_q <= next_q[ptr_q];
        end
        if (walk_q) begin
            reply_o.dst   <= dst_q[ptr_q];
            reply_o.last  <= empty_q || tail_q[ptr_q];
            reply_o.empty <= empty_q;
        end
    end

    a_one_query: assert property (@(posedge tck) disable iff (!rst_n_i)
        query_valid_i |-> !pending_q);

    a_edge_room: assert property (@(posedge tck) disable iff (!rst_n_i)
        edge_valid_i |-> edge_cnt_q < `GRAPH_MAX_EDGES);

endmodule

`default_nettype wire

//--- edge_parser.sv
`timescale 1ns/1ps
`default_nettype none
`include "graph_settings.svh"

module edge_parser (
    input  wire                          tck,
    input  wire                          rst_n_i,
    input  wire                          byte_valid_i,
    input  wire [`GRAPH_BYTE_WIDTH-1:0]  byte_data_i,
    output logic                         edge_valid_o,
    output graph_pkg::edge_s             edge_o,
    output graph_pkg::graph_info_s       info_o,
    output logic                         graph_done_o
);

    graph_pkg::parse_state_e state_q;
    graph_pkg::node_t        node;
    graph_pkg::node_cnt_t    seen_cnt;

    // Operand bytes carry the node index in their low bits
    assign node = graph_pkg::node_t'(byte_data_i);

    // Node count grows to cover the highest index named so far
    assign seen_cnt = (graph_pkg::node_cnt_t'(node) + 1'b1 > info_o.node_cnt) ?
                      graph_pkg::node_cnt_t'(node) + 1'b1 : info_o.node_cnt;

    always_ff @(posedge tck) begin
        if (!rst_n_i) begin
            state_q      <= graph_pkg::PS_OPCODE;
            edge_valid_o <= 1'b0;
            graph_done_o <= 1'b0;
            info_o       <= '0;
        end else begin
            edge_valid_o <= 1'b0;
            graph_done_o <= 1'b0;
            if (byte_valid_i) begin
                case (state_q)
                    graph_pkg::PS_OPCODE: begin
                        // Unknown opcodes fall through and are dropped
                        case (graph_pkg::opcode_e'(byte_data_i))
                            graph_pkg::OP_EDGE:  state_q <= graph_pkg::PS_EDGE_SRC;
                            graph_pkg::OP_START: state_q <= graph_pkg::PS_START;
                            graph_pkg::OP_END:   state_q <= graph_pkg::PS_END;
                            graph_pkg::OP_DONE:  graph_done_o <= 1'b1;
                            default:             state_q <= graph_pkg::PS_OPCODE;
                        endcase
                    end
                    graph_pkg::PS_EDGE_SRC: begin
                        edge_o.src      <= node;
                        info_o.node_cnt <= seen_cnt;
                        state_q         <= graph_pkg::PS_EDGE_DST;
                    end
                    graph_pkg::PS_EDGE_DST: begin
                        edge_o.dst      <= node;
                        edge_valid_o    <= 1'b1;
                        info_o.node_cnt <= seen_cnt;
                        state_q         <= graph_pkg::PS_OPCODE;
                    end
                    graph_pkg::PS_START: begin
                        info_o.start_node <= node;
                        info_o.node_cnt   <= seen_cnt;
                        state_q           <= graph_pkg::PS_OPCODE;
                    end
                    default: begin
                        info_o.end_node <= node;
                        info_o.node_cnt <= seen_cnt;
                        state_q         <= graph_pkg::PS_OPCODE;
                    end
                endcase
            end
        end
    end

    // Host must send node indices that fit the stores
    a_operand_range: assert property (@(posedge tck) disable iff (!rst_n_i)
        byte_valid_i && state_q != graph_pkg::PS_OPCODE |-> byte_data_i < `GRAPH_MAX_NODES);

endmodule

`default_nettype wire

//--- graph_pkg.sv
`default_nettype none
`include "graph_settings.svh"

package graph_pkg;

    typedef logic [$clog2(`GRAPH_MAX_NODES)-1:0] node_t;
    typedef logic [$clog2(`GRAPH_MAX_EDGES)-1:0] edge_idx_t;
    typedef logic [`GRAPH_RESULT_WIDTH-1:0]      count_t;

    // One bit wider than an index, so a full graph still fits
    typedef logic [$clog2(`GRAPH_MAX_NODES):0] node_cnt_t;

    // Every stored edge could land on the same node
    typedef logic [$clog2(`GRAPH_MAX_EDGES):0] deg_t;

    typedef enum logic [`GRAPH_BYTE_WIDTH-1:0] {
        OP_EDGE  = 8'h01,
        OP_START = 8'h02,
        OP_END   = 8'h03,
        OP_DONE  = 8'h04
    } opcode_e;

    typedef struct packed {
        node_t src;
        node_t dst;
    } edge_s;

    typedef struct packed {
        node_t     start_node;
        node_t     end_node;
        node_cnt_t node_cnt;
    } graph_info_s;

    typedef struct packed {
        node_t node;
    } query_s;

    typedef struct packed {
        node_t dst;
        logic  last;
        logic  empty;
    } reply_s;

    // Ready sits in bit 0 so it is the first bit on TDO
    typedef struct packed {
        count_t count;
        logic   ready;
    } result_s;

    typedef enum logic [2:0] {
        PS_OPCODE,
        PS_EDGE_SRC,
        PS_EDGE_DST,
        PS_START,
        PS_END
    } parse_state_e;

    typedef enum logic [2:0] {
        WS_IDLE,
        WS_SEED,
        WS_POP,
        WS_QUERY,
        WS_REPLY,
        WS_DONE
    } walk_state_e;

endpackage

`default_nettype wire

//--- graph_settings.svh
`ifndef GRAPH_SETTINGS_SVH
`define GRAPH_SETTINGS_SVH

// Node indices arrive already mapped into 0 .. GRAPH_MAX_NODES-1
`define GRAPH_MAX_NODES 64

// Total edges the adjacency map can hold
`define GRAPH_MAX_EDGES 128

// Path count wraps modulo 2^GRAPH_RESULT_WIDTH
`define GRAPH_RESULT_WIDTH 16

// One DR update carries one byte
`define GRAPH_BYTE_WIDTH 8

`endif

//--- indegree_list.sv
`timescale 1ns/1ps
`default_nettype none
`include "graph_settings.svh"

module indegree_list (
    input  wire                    tck,
    input  wire                    rst_n_i,
    input  wire                    edge_valid_i,
    input  wire graph_pkg::edge_s  edge_i,
    input  wire                    dec_valid_i,
    input  wire graph_pkg::node_t  dec_node_i,
    input  wire graph_pkg::node_t  rd_node_i,
    output graph_pkg::deg_t        dec_degree_o,
    output graph_pkg::deg_t        rd_degree_o
);

    graph_pkg::deg_t deg_q [`GRAPH_MAX_NODES];

    // Edges raise the destination count, the walker lowers it
    always_ff @(posedge tck) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `GRAPH_MAX_NODES; i++) begin
                deg_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `GRAPH_MAX_NODES; i++) begin
                deg_q[i] <= deg_q[i]
                    + graph_pkg::deg_t'(edge_valid_i && edge_i.dst == graph_pkg::node_t'(i))
                    - graph_pkg::deg_t'(dec_valid_i && dec_node_i == graph_pkg::node_t'(i));
            end
        end
    end

    // Both ports answer one cycle after the request
    always_ff @(posedge tck) begin
        dec_degree_o <= deg_q[dec_node_i] - 1'b1;
        rd_degree_o  <= deg_q[rd_node_i];
    end

    a_no_underflow: assert property (@(posedge tck) disable iff (!rst_n_i)
        dec_valid_i |-> deg_q[dec_node_i] != '0);

endmodule

`default_nettype wire

//--- path_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "graph_settings.svh"

module path_counter (
    input  wire                         tck,
    input  wire                         rst_n_i,
    input  wire graph_pkg::graph_info_s info_i,
    input  wire                         graph_done_i,
    output logic                        query_valid_o,
    output graph_pkg::query_s           query_o,
    input  wire                         reply_valid_i,
    input  wire graph_pkg::reply_s      reply_i,
    output logic                        dec_valid_o,
    output graph_pkg::node_t            dec_node_o,
    output graph_pkg::node_t            rd_node_o,
    input  wire graph_pkg::deg_t        dec_degree_i,
    input  wire graph_pkg::deg_t        rd_degree_i,
    output graph_pkg::result_s          result_o
);

    graph_pkg::walk_state_e state_q;
    graph_pkg::count_t      cnt_q  [`GRAPH_MAX_NODES];
    graph_pkg::node_t       fifo_q [`GRAPH_MAX_NODES];

    graph_pkg::node_t     wr_ptr_q;
    graph_pkg::node_t     rd_ptr_q;
    graph_pkg::node_cnt_t fill_q;
    graph_pkg::node_cnt_t scan_q;
    graph_pkg::node_t     cur_q;

    // Degree checks in flight, one from seeding and one from a reply beat
    logic             chk_q;
    graph_pkg::node_t chk_node_q;
    logic             dec_q;
    graph_pkg::node_t dec_node_q;

    logic             beat;
    logic             push;
    logic             pop;
    graph_pkg::node_t push_node;

    assign rd_node_o     = graph_pkg::node_t'(scan_q);
    assign query_valid_o = state_q == graph_pkg::WS_QUERY;
    assign query_o.node  = cur_q;

    assign beat        = state_q == graph_pkg::WS_REPLY && reply_valid_i;
    assign dec_valid_o = beat && !reply_i.empty;
    assign dec_node_o  = reply_i.dst;

    // A node joins the queue once no incoming edge is left
    assign push      = (chk_q && rd_degree_i == '0) || (dec_q && dec_degree_i == '0);
    assign push_node = chk_q ? chk_node_q : dec_node_q;
    // Hold off while a decrement result is still on its way
    assign pop       = state_q == graph_pkg::WS_POP && !dec_q && fill_q != '0;

    always_ff @(posedge tck) begin
        if (!rst_n_i) begin
            state_q  <= graph_pkg::WS_IDLE;
            chk_q    <= 1'b0;
            dec_q    <= 1'b0;
            fill_q   <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            scan_q   <= '0;
            result_o <= '0;
        end else begin
            chk_q  <= 1'b0;
            dec_q  <= dec_valid_o;
            fill_q <= fill_q + graph_pkg::node_cnt_t'(push) - graph_pkg::node_cnt_t'(pop);
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case (state_q)
                graph_pkg::WS_IDLE, graph_pkg::WS_DONE: begin
                    if (graph_done_i) begin
                        state_q        <= graph_pkg::WS_SEED;
                        scan_q         <= '0;
                        result_o.ready <= 1'b0;
                    end
                end
                graph_pkg::WS_SEED: begin
                    // One extra cycle lets the last degree check land
                    chk_q  <= scan_q < info_i.node_cnt;
                    scan_q <= scan_q + 1'b1;
                    if (scan_q == info_i.node_cnt) begin
                        state_q <= graph_pkg::WS_POP;
                    end
                end
                graph_pkg::WS_POP: begin
                    if (pop) begin
                        state_q <= graph_pkg::WS_QUERY;
                    end else if (!dec_q) begin
                        state_q        <= graph_pkg::WS_DONE;
                        result_o.count <= cnt_q[info_i.end_node];
                        result_o.ready <= 1'b1;
                    end
                end
                graph_pkg::WS_QUERY: begin
                    state_q <= graph_pkg::WS_REPLY;
                end
                graph_pkg::WS_REPLY: begin
                    if (beat && reply_i.last) begin
                        state_q <= graph_pkg::WS_POP;
                    end
                end
                default: begin
                    state_q <= graph_pkg::WS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge tck) begin
        chk_node_q <= rd_node_o;
        dec_node_q <= reply_i.dst;
        if (push) begin
            fifo_q[wr_ptr_q] <= push_node;
        end
        if (pop) begin
            cur_q <= fifo_q[rd_ptr_q];
        end
        // Seeding clears every count except the start node
        if (state_q == graph_pkg::WS_SEED && scan_q < info_i.node_cnt) begin
            cnt_q[rd_node_o] <= graph_pkg::count_t'(rd_node_o == info_i.start_node);
        end else if (dec_valid_o) begin
            cnt_q[reply_i.dst] <= cnt_q[reply_i.dst] + cnt_q[cur_q];
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the user_logic testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module user_logic_tb -f user_logic.f --Mdir "$OBJ"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ/Vuser_logic_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- tap_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "graph_settings.svh"

module tap_decoder (
    input  wire                          tck,
    input  wire                          rst_n_i,
    input  wire                          test_logic_reset_i,
    input  wire                          ir_is_user_i,
    input  wire                          shift_dr_i,
    input  wire                          update_dr_i,
    input  wire                          tdi_i,
    output logic                         byte_valid_o,
    output logic [`GRAPH_BYTE_WIDTH-1:0] byte_data_o
);

    logic [`GRAPH_BYTE_WIDTH-1:0] shift_q;

    // TDI enters at the top, so the first bit ends in bit 0
    always_ff @(posedge tck) begin
        if (!rst_n_i || test_logic_reset_i) begin
            shift_q <= '0;
        end else if (shift_dr_i && ir_is_user_i) begin
            shift_q <= {tdi_i, shift_q[`GRAPH_BYTE_WIDTH-1:1]};
        end
    end

    always_ff @(posedge tck) begin
        if (!rst_n_i) begin
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= update_dr_i && ir_is_user_i;
        end
    end

    always_ff @(posedge tck) begin
        if (update_dr_i && ir_is_user_i) begin
            byte_data_o <= shift_q;
        end
    end

endmodule

`default_nettype wire

//--- tap_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tap_encoder (
    input  wire                     tck,
    input  wire                     rst_n_i,
    input  wire                     test_logic_reset_i,
    input  wire                     ir_is_user_i,
    input  wire                     capture_dr_i,
    input  wire                     shift_dr_i,
    input  wire graph_pkg::result_s result_i,
    output logic                    tdo_o
);

    logic [$bits(graph_pkg::result_s)-1:0] shift_q;

    // Bit 0 drives TDO, so ready leaves first and the count follows LSB first
    always_ff @(posedge tck) begin
        if (!rst_n_i || test_logic_reset_i) begin
            shift_q <= '0;
        end else if (ir_is_user_i && capture_dr_i) begin
            shift_q <= result_i;
        end else if (ir_is_user_i && shift_dr_i) begin
            shift_q <= {1'b0, shift_q[$bits(graph_pkg::result_s)-1:1]};
        end
    end

    assign tdo_o = shift_q[0];

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic tck_o,
    output logic rst_n_o
);

    initial begin
        tck_o = 1'b0;
        forever #(PERIOD_NS / 2) tck_o = ~tck_o;
    end

    // Release on a falling edge like the rest of the stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge tck_o);
        @(negedge tck_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- user_logic.f
+incdir+.
graph_pkg.sv
tap_decoder.sv
edge_parser.sv
adjacency_map.sv
indegree_list.sv
path_counter.sv
tap_encoder.sv
user_logic.sv
tb_clock_gen.sv
user_logic_tb.sv

//--- user_logic.sv
`timescale 1ns/1ps
`default_nettype none
`include "graph_settings.svh"

module user_logic (
    input  wire  tck,
    input  wire  rst_n_i,
    input  wire  test_logic_reset_i,
    input  wire  ir_is_user_i,
    input  wire  capture_dr_i,
    input  wire  shift_dr_i,
    input  wire  update_dr_i,
    input  wire  tdi_i,
    output logic tdo_o
);

    logic                         byte_valid;
    logic [`GRAPH_BYTE_WIDTH-1:0] byte_data;

    logic                   edge_valid;
    graph_pkg::edge_s       new_edge;
    graph_pkg::graph_info_s info;
    logic                   graph_done;

    logic              query_valid;
    graph_pkg::query_s query;
    logic              reply_valid;
    graph_pkg::reply_s reply;

    logic               dec_valid;
    graph_pkg::node_t   dec_node;
    graph_pkg::node_t   rd_node;
    graph_pkg::deg_t    dec_degree;
    graph_pkg::deg_t    rd_degree;
    graph_pkg::result_s result;

    tap_decoder u_decoder (
        .tck                (tck),
        .rst_n_i            (rst_n_i),
        .test_logic_reset_i (test_logic_reset_i),
        .ir_is_user_i       (ir_is_user_i),
        .shift_dr_i         (shift_dr_i),
        .update_dr_i        (update_dr_i),
        .tdi_i              (tdi_i),
        .byte_valid_o       (byte_valid),
        .byte_data_o        (byte_data)
    );

    edge_parser u_parser (
        .tck          (tck),
        .rst_n_i      (rst_n_i),
        .byte_valid_i (byte_valid),
        .byte_data_i  (byte_data),
        .edge_valid_o (edge_valid),
        .edge_o       (new_edge),
        .info_o       (info),
        .graph_done_o (graph_done)
    );

    // Both stores fill from the same edge stream
    adjacency_map u_adjacency (
        .tck           (tck),
        .rst_n_i       (rst_n_i),
        .edge_valid_i  (edge_valid),
        .edge_i        (new_edge),
        .query_valid_i (query_valid),
        .query_i       (query),
        .reply_valid_o (reply_valid),
        .reply_o       (reply)
    );

    indegree_list u_indegree (
        .tck          (tck),
        .rst_n_i      (rst_n_i),
        .edge_valid_i (edge_valid),
        .edge_i       (new_edge),
        .dec_valid_i  (dec_valid),
        .dec_node_i   (dec_node),
        .rd_node_i    (rd_node),
        .dec_degree_o (dec_degree),
        .rd_degree_o  (rd_degree)
    );

    path_counter u_counter (
        .tck           (tck),
        .rst_n_i       (rst_n_i),
        .info_i        (info),
        .graph_done_i  (graph_done),
        .query_valid_o (query_valid),
        .query_o       (query),
        .reply_valid_i (reply_valid),
        .reply_i       (reply),
        .dec_valid_o   (dec_valid),
        .dec_node_o    (dec_node),
        .rd_node_o     (rd_node),
        .dec_degree_i  (dec_degree),
        .rd_degree_i   (rd_degree),
        .result_o      (result)
    );

    tap_encoder u_encoder (
        .tck                (tck),
        .rst_n_i            (rst_n_i),
        .test_logic_reset_i (test_logic_reset_i),
        .ir_is_user_i       (ir_is_user_i),
        .capture_dr_i       (capture_dr_i),
        .shift_dr_i         (shift_dr_i),
        .result_i           (result),
        .tdo_o              (tdo_o)
    );

endmodule

`default_nettype wire

//--- user_logic_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "graph_settings.svh"

module user_logic_tb;

    localparam int POLL_LIMIT  = 24;
    localparam int POLL_GAP    = 4;
    localparam int READ_CYCLES = 18;
    localparam int BYTE_CYCLES = 12;
    localparam int RAND_NODES  = 24;
    localparam int RAND_EDGES  = 100;
    localparam int GRAPH_RUNS  = 10;
    // Hand-written graphs hold 25 edges, the ignored edge adds 3 bytes
    localparam int TOTAL_EDGES = 25 + 3 * RAND_EDGES;
    localparam int TOTAL_BYTES = 3 * TOTAL_EDGES + 5 * GRAPH_RUNS + 3;
    localparam int POLL_BUDGET = POLL_LIMIT * (READ_CYCLES + POLL_GAP);
    localparam int TIMEOUT_CYCLES = (TOTAL_BYTES * BYTE_CYCLES
        + GRAPH_RUNS * 4 * `GRAPH_MAX_NODES + 4 * TOTAL_EDGES
        + GRAPH_RUNS * POLL_BUDGET) * 3 / 2;

    logic tck;
    logic por_n;
    logic soft_rst_n;
    logic rst_n;
    logic test_logic_reset;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic tdi;
    logic tdo;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int n_edges = 0;
    int e_src [`GRAPH_MAX_EDGES];
    int e_dst [`GRAPH_MAX_EDGES];
    int start_node;

    assign rst_n = por_n & soft_rst_n;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) u_clock_gen (
        .tck_o   (tck),
        .rst_n_o (por_n)
    );

    user_logic u_dut (
        .tck                (tck),
        .rst_n_i            (rst_n),
        .test_logic_reset_i (test_logic_reset),
        .ir_is_user_i       (ir_is_user),
        .capture_dr_i       (capture_dr),
        .shift_dr_i         (shift_dr),
        .update_dr_i        (update_dr),
        .tdi_i              (tdi),
        .tdo_o              (tdo)
    );

    // Kahn order over the recorded edges, counts kept modulo 2^16
    function automatic int model_count(input int from_node, input int to_node);
        int deg [`GRAPH_MAX_NODES];
        int cnt [`GRAPH_MAX_NODES];
        int ready_q [$];
        int n;
        for (int i = 0; i < `GRAPH_MAX_NODES; i++) begin
            deg[i] = 0;
            cnt[i] = 0;
        end
        for (int e = 0; e < n_edges; e++) begin
            deg[e_dst[e]]++;
        end
        cnt[from_node] = 1;
        for (int i = 0; i < `GRAPH_MAX_NODES; i++) begin
            if (deg[i] == 0) begin
                ready_q.push_back(i);
            end
        end
        while (ready_q.size() > 0) begin
            n = ready_q.pop_front();
            for (int e = 0; e < n_edges; e++) begin
                if (e_src[e] == n) begin
                    cnt[e_dst[e]] = (cnt[e_dst[e]] + cnt[n]) & 'hffff;
                    deg[e_dst[e]]--;
                    if (deg[e_dst[e]] == 0) begin
                        ready_q.push_back(e_dst[e]);
                    end
                end
            end
        end
        return cnt[to_node];
    endfunction

    task automatic apply_reset();
        @(negedge tck);
        soft_rst_n = 1'b0;
        repeat (2) @(negedge tck);
        soft_rst_n = 1'b1;
    endtask

    // LSB first, then one update cycle and two idle cycles
    task automatic send_byte(input logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            @(negedge tck);
            shift_dr = 1'b1;
            tdi      = value[i];
        end
        @(negedge tck);
        shift_dr  = 1'b0;
        update_dr = 1'b1;
        @(negedge tck);
        update_dr = 1'b0;
        repeat (2) @(negedge tck);
    endtask

    task automatic send_edge(input int src, input int dst);
        send_byte(graph_pkg::OP_EDGE);
        send_byte(8'(src));
        send_byte(8'(dst));
    endtask

    task automatic add_edge(input int src, input int dst);
        e_src[n_edges] = src;
        e_dst[n_edges] = dst;
        n_edges++;
        send_edge(src, dst);
    endtask

    task automatic new_graph();
        apply_reset();
        n_edges = 0;
    endtask

    // Ready comes out first, then the count LSB first
    task automatic read_result(output logic ready, output logic [15:0] count);
        logic [16:0] bits;
        @(negedge tck);
        capture_dr = 1'b1;
        @(negedge tck);
        capture_dr = 1'b0;
        bits[0]    = tdo;
        for (int i = 1; i < 17; i++) begin
            shift_dr = 1'b1;
            @(negedge tck);
            bits[i] = tdo;
        end
        shift_dr = 1'b0;
        ready    = bits[0];
        count    = bits[16:1];
    endtask

    task automatic check_count(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        assert (actual == expected)
        else begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_ready(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual == expected)
        else begin
            errors++;
            $display("FAILED %s ready: expected %0b, actual %0b", name, expected, actual);
        end
    endtask

    task automatic poll_result(input string name, output logic ready,
                               output logic [15:0] count);
        int polls;
        polls = 0;
        ready = 1'b0;
        count = '0;
        while (!ready && polls < POLL_LIMIT) begin
            read_result(ready, count);
            polls++;
            if (!ready) begin
                repeat (POLL_GAP) @(negedge tck);
            end
        end
        checks++;
        assert (ready)
        else begin
            errors++;
            $display("Test %s: result never showed ready after %0d reads", name, polls);
        end
    endtask

    task automatic solve_and_check(input string name, input int from_node, input int to_node);
        logic        ready;
        logic [15:0] count;
        send_byte(graph_pkg::OP_START);
        send_byte(8'(from_node));
        send_byte(graph_pkg::OP_END);
        send_byte(8'(to_node));
        send_byte(graph_pkg::OP_DONE);
        poll_result(name, ready, count);
        if (ready) begin
            check_count(name, 16'(model_count(from_node, to_node)), count);
        end
    endtask

    // Backbone chain plus extra forward edges, mostly from low nodes
    task automatic build_random_dag(output int from_node);
        int src;
        int dst;
        for (int i = 0; i < RAND_NODES - 1; i++) begin
            add_edge(i, i + 1);
        end
        for (int i = RAND_NODES - 1; i < RAND_EDGES; i++) begin
            if ($urandom % 2 == 0) begin
                src = int'($urandom % 4);
            end else begin
                src = int'($urandom % (RAND_NODES - 1));
            end
            dst = src + 1 + int'($urandom % (RAND_NODES - 1 - src));
            add_edge(src, dst);
        end
        from_node = int'($urandom % 3);
    endtask

    always @(posedge tck) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run stopped making progress", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        logic        ready;
        logic [15:0] count;
        test_logic_reset = 1'b0;
        ir_is_user       = 1'b1;
        capture_dr       = 1'b0;
        shift_dr         = 1'b0;
        update_dr        = 1'b0;
        tdi              = 1'b0;
        soft_rst_n       = 1'b1;
        void'($urandom(1689));
        wait (por_n === 1'b1);

        new_graph();
        add_edge(0, 1);
        add_edge(1, 2);
        add_edge(2, 3);
        solve_and_check("chain", 0, 3);

        new_graph();
        add_edge(0, 1);
        add_edge(0, 2);
        add_edge(1, 3);
        add_edge(2, 3);
        solve_and_check("diamond", 0, 3);

        // Second copy of 1->3 adds its own path
        new_graph();
        add_edge(0, 1);
        add_edge(0, 2);
        add_edge(1, 3);
        add_edge(2, 3);
        add_edge(1, 3);
        solve_and_check("diamond_dup", 0, 3);

        new_graph();
        add_edge(0, 1);
        add_edge(1, 2);
        add_edge(0, 2);
        solve_and_check("unreachable", 2, 0);

        new_graph();
        add_edge(0, 1);
        add_edge(1, 2);
        add_edge(0, 2);
        read_result(ready, count);
        check_ready("not_ready", 1'b0, ready);
        ir_is_user = 1'b0;
        send_edge(0, 1);
        ir_is_user = 1'b1;
        solve_and_check("not_ready", 0, 2);

        new_graph();
        add_edge(0, 1);
        add_edge(0, 1);
        add_edge(0, 1);
        add_edge(1, 2);
        solve_and_check("reset_reuse_a", 0, 2);
        // Old edges into 1 and 2 would raise the count into 3
        new_graph();
        add_edge(0, 2);
        add_edge(2, 3);
        add_edge(0, 3);
        solve_and_check("reset_reuse_b", 0, 3);

        for (int d = 0; d < 3; d++) begin
            new_graph();
            build_random_dag(start_node);
            solve_and_check($sformatf("random_dag_%0d", d), start_node, RAND_NODES - 1);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
